/* design/bchPkg.sv */
package bchPkg;

	// **********************************************************************
	// code constants for the binary BCH(15,5) code with t = 3
	// **********************************************************************

	localparam int codeLen = 15;
	localparam int msgLen = 5;
	localparam int parityLen = 10;
	localparam int corrCap = 3;
	localparam int gfBits = 4;

	// x^10 + x^8 + x^5 + x^4 + x^2 + x + 1, the product of the minimal polynomials of alpha,
	// alpha^3 and alpha^5.
	localparam logic [parityLen:0] genPoly = 11'h537;

	// x^4 + x + 1.
	localparam logic [gfBits:0] primPoly = 5'b10011;

	typedef logic [msgLen-1:0] msgWord;
	typedef logic [codeLen-1:0] codeWord;
	typedef logic [gfBits-1:0] gfElem;
	typedef logic [3:0] bitIndex;

	localparam bitIndex lastBit = bitIndex'(codeLen - 1);

	// powers of alpha in the polynomial basis.
	localparam gfElem gfOne = 4'h1;
	localparam gfElem alpha1 = 4'h2;
	localparam gfElem alpha2 = 4'h4;
	localparam gfElem alpha3 = 4'h8;
	localparam gfElem alpha5 = 4'h6;

	typedef enum logic [1:0] {locIdle, locIterate, locUpdate, locDone} locState;

	// shift-and-add multiply, reducing by primPoly after every shift.
	function automatic gfElem gfMul(input gfElem a, input gfElem b);
		gfElem acc;
		gfElem shifted;
		acc = '0;
		shifted = a;
		for (int i = 0; i < gfBits; i++) begin
			if (b[i])
				acc = acc ^ shifted;
			shifted = {shifted[gfBits-2:0], 1'b0} ^ (shifted[gfBits-1] ? primPoly[gfBits-1:0] : '0);
		end
		return acc;
	endfunction

	// squaring is linear in GF(2^m), so it reduces to a few XORs for x^4 + x + 1.
	function automatic gfElem gfSquare(input gfElem a);
		return {a[3], a[1] ^ a[3], a[2], a[0] ^ a[2]};
	endfunction

endpackage

/* design/bchEncoder.sv */
`timescale 1ns/100ps

module bchEncoder (
	input  logic           clk,
	input  logic           reset,
	input  logic           load,
	input  bchPkg::msgWord msg,
	output logic           codeBit,
	output logic           bitValid
);
	import bchPkg::*;

	msgWord msgShift;
	logic [parityLen-1:0] parity;
	bitIndex bitCount;
	logic msgPhase;
	logic feedback;

	// the message goes out first, its LSB being the highest-degree coefficient.
	assign msgPhase = (bitCount < bitIndex'(msgLen));
	assign feedback = msgShift[0] ^ parity[parityLen-1];
	assign codeBit = msgPhase ? msgShift[0] : parity[parityLen-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			bitValid <= 1'b0;
			bitCount <= '0;
		end else if (load) begin
			bitValid <= 1'b1;
			bitCount <= '0;
		end else if (bitValid) begin
			bitCount <= bitCount + 1'b1;
			if (bitCount == lastBit)
				bitValid <= 1'b0;
		end
	end

	// division by genPoly while the message passes; afterwards the remainder shifts out.
	always_ff @(posedge clk) begin
		if (load) begin
			msgShift <= msg;
			parity <= '0;
		end else if (bitValid) begin
			if (msgPhase) begin
				msgShift <= msgShift >> 1;
				parity <= {parity[parityLen-2:0], 1'b0} ^
					(feedback ? genPoly[parityLen-1:0] : '0);
			end else begin
				parity <= {parity[parityLen-2:0], 1'b0};
			end
		end
	end

endmodule

/* design/syndromeUnit.sv */
`timescale 1ns/100ps

module syndromeUnit (
	input  logic          clk,
	input  logic          reset,
	input  logic          rxBit,
	input  logic          rxValid,
	output logic          synValid,
	output bchPkg::gfElem syn1,
	output bchPkg::gfElem syn2,
	output bchPkg::gfElem syn3,
	output bchPkg::gfElem syn4,
	output bchPkg::gfElem syn5,
	output bchPkg::gfElem syn6
);
	import bchPkg::*;

	gfElem acc1;
	gfElem acc3;
	gfElem acc5;
	gfElem base1;
	gfElem base3;
	gfElem base5;
	gfElem bitElem;
	bitIndex bitCount;
	logic firstBit;

	assign firstBit = (bitCount == '0);
	assign bitElem = {{(gfBits-1){1'b0}}, rxBit};

	// a new word starts the Horner chains from zero.
	assign base1 = firstBit ? '0 : acc1;
	assign base3 = firstBit ? '0 : acc3;
	assign base5 = firstBit ? '0 : acc5;

	always_ff @(posedge clk) begin
		if (reset) begin
			synValid <= 1'b0;
			bitCount <= '0;
		end else begin
			synValid <= rxValid && (bitCount == lastBit);
			if (rxValid)
				bitCount <= (bitCount == lastBit) ? '0 : bitCount + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rxValid) begin
			acc1 <= gfMul(base1, alpha1) ^ bitElem;
			acc3 <= gfMul(base3, alpha3) ^ bitElem;
			acc5 <= gfMul(base5, alpha5) ^ bitElem;
		end
	end

	// for a binary code S(2i) = S(i)^2.
	assign syn1 = acc1;
	assign syn2 = gfSquare(acc1);
	assign syn3 = acc3;
	assign syn4 = gfSquare(syn2);
	assign syn5 = acc5;
	assign syn6 = gfSquare(acc3);

endmodule

/* design/errorLocator.sv */
`timescale 1ns/100ps

module errorLocator (
	input  logic          clk,
	input  logic          reset,
	input  logic          synValid,
	input  bchPkg::gfElem syn1,
	input  bchPkg::gfElem syn2,
	input  bchPkg::gfElem syn3,
	input  bchPkg::gfElem syn4,
	input  bchPkg::gfElem syn5,
	input  bchPkg::gfElem syn6,
	output logic          locValid,
	output bchPkg::gfElem lambda0,
	output bchPkg::gfElem lambda1,
	output bchPkg::gfElem lambda2,
	output bchPkg::gfElem lambda3
);
	import bchPkg::*;

	locState state;
	logic [1:0] iterCount;

	gfElem lam [0:corrCap];
	gfElem aux [0:corrCap];
	gfElem synWin [0:8];
	gfElem gamma;
	gfElem delta;
	gfElem discr;
	logic signed [3:0] degDiff;
	logic swap;

	// **********************************************************************
	// control
	// **********************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= locIdle;
			iterCount <= '0;
		end else begin
			case (state)
				locIdle: begin
					iterCount <= '0;
					if (synValid)
						state <= locIterate;
				end
				locIterate: state <= locUpdate;
				locUpdate: begin
					iterCount <= iterCount + 1'b1;
					state <= (iterCount == 2'(corrCap - 1)) ? locDone : locIterate;
				end
				default: state <= locIdle;
			endcase
		end
	end

	assign locValid = (state == locDone);

	// **********************************************************************
	// datapath
	// **********************************************************************

	// the syndrome window shifts by two per iteration, so fixed taps see
	// S(2r+1) down to S(2r-2), with zeros below S1.
	always_comb begin
		discr = '0;
		for (int j = 0; j <= corrCap; j++)
			discr = discr ^ gfMul(lam[j], synWin[corrCap-j]);
	end

	assign swap = (delta != '0) && !degDiff[3];

	always_ff @(posedge clk) begin
		if (synValid) begin
			lam[0] <= gfOne;
			aux[0] <= gfOne;
			for (int j = 1; j <= corrCap; j++) begin
				lam[j] <= '0;
				aux[j] <= '0;
			end
			gamma <= gfOne;
			degDiff <= '0;
			synWin[0] <= '0;
			synWin[1] <= '0;
			synWin[2] <= '0;
			synWin[3] <= syn1;
			synWin[4] <= syn2;
			synWin[5] <= syn3;
			synWin[6] <= syn4;
			synWin[7] <= syn5;
			synWin[8] <= syn6;
		end else if (state == locIterate) begin
			delta <= discr;
		end else if (state == locUpdate) begin
			// lambda <= gamma * lambda + delta * x * aux.
			lam[0] <= gfMul(gamma, lam[0]);
			for (int j = 1; j <= corrCap; j++)
				lam[j] <= gfMul(gamma, lam[j]) ^ gfMul(delta, aux[j-1]);
			aux[0] <= '0;
			if (swap) begin
				for (int j = 1; j <= corrCap; j++)
					aux[j] <= lam[j-1];
				gamma <= delta;
				degDiff <= -degDiff;
			end else begin
				// the even step has no discrepancy, hence x^2 here.
				aux[1] <= '0;
				for (int j = 2; j <= corrCap; j++)
					aux[j] <= aux[j-2];
				degDiff <= degDiff + 4'sd2;
			end
			for (int i = 0; i < 7; i++)
				synWin[i] <= synWin[i+2];
			synWin[7] <= '0;
			synWin[8] <= '0;
		end
	end

	assign lambda0 = lam[0];
	assign lambda1 = lam[1];
	assign lambda2 = lam[2];
	assign lambda3 = lam[3];

endmodule

/* design/chienCorrector.sv */
`timescale 1ns/100ps

module chienCorrector (
	input  logic            clk,
	input  logic            reset,
	input  logic            locValid,
	input  bchPkg::gfElem   lambda0,
	input  bchPkg::gfElem   lambda1,
	input  bchPkg::gfElem   lambda2,
	input  bchPkg::gfElem   lambda3,
	input  bchPkg::codeWord rxWord,
	output logic            corrValid,
	output bchPkg::codeWord corrWord
);
	import bchPkg::*;

	gfElem term0;
	gfElem term1;
	gfElem term2;
	gfElem term3;
	gfElem evalSum;
	codeWord work;
	bitIndex pos;
	logic active;

	// position k of the word is degree 14 - k, whose locator root is alpha^(k + 1).
	assign evalSum = term0 ^ term1 ^ term2 ^ term3;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			corrValid <= 1'b0;
			pos <= '0;
		end else begin
			corrValid <= active && (pos == lastBit);
			if (locValid) begin
				active <= 1'b1;
				pos <= '0;
			end else if (active) begin
				pos <= pos + 1'b1;
				if (pos == lastBit)
					active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (locValid) begin
			// terms start at lambda(i) * alpha^i, the value for position 0.
			term0 <= lambda0;
			term1 <= gfMul(lambda1, alpha1);
			term2 <= gfMul(lambda2, alpha2);
			term3 <= gfMul(lambda3, alpha3);
			work <= rxWord;
		end else if (active) begin
			term1 <= gfMul(term1, alpha1);
			term2 <= gfMul(term2, alpha2);
			term3 <= gfMul(term3, alpha3);
			if (evalSum == '0)
				work[pos] <= ~work[pos];
		end
	end

	assign corrWord = work;

endmodule

/* design/bchDecoder.sv */
`timescale 1ns/100ps

module bchDecoder (
	input  logic           clk,
	input  logic           reset,
	input  logic           rxBit,
	input  logic           rxValid,
	output logic           doneValid,
	output bchPkg::msgWord decMsg
);
	import bchPkg::*;

	codeWord rxBuf;
	codeWord corrWord;
	logic synValid;
	logic locValid;
	logic corrValid;
	gfElem syn1, syn2, syn3, syn4, syn5, syn6;
	gfElem lambda0, lambda1, lambda2, lambda3;

	// bit k of the buffer holds the k-th received bit.
	always_ff @(posedge clk) begin
		if (rxValid)
			rxBuf <= {rxBit, rxBuf[codeLen-1:1]};
	end

	syndromeUnit syndromes (
		.clk(clk), .reset(reset),
		.rxBit(rxBit), .rxValid(rxValid),
		.synValid(synValid),
		.syn1(syn1), .syn2(syn2), .syn3(syn3),
		.syn4(syn4), .syn5(syn5), .syn6(syn6)
	);

	errorLocator locator (
		.clk(clk), .reset(reset),
		.synValid(synValid),
		.syn1(syn1), .syn2(syn2), .syn3(syn3),
		.syn4(syn4), .syn5(syn5), .syn6(syn6),
		.locValid(locValid),
		.lambda0(lambda0), .lambda1(lambda1), .lambda2(lambda2), .lambda3(lambda3)
	);

	chienCorrector corrector (
		.clk(clk), .reset(reset),
		.locValid(locValid),
		.lambda0(lambda0), .lambda1(lambda1), .lambda2(lambda2), .lambda3(lambda3),
		.rxWord(rxBuf),
		.corrValid(corrValid), .corrWord(corrWord)
	);

	assign doneValid = corrValid;
	assign decMsg = corrWord[msgLen-1:0];

endmodule

/* design/bchLoopback.sv */
`timescale 1ns/100ps

module bchLoopback (
	input  logic            clk,
	input  logic            reset,
	input  logic            start,
	input  bchPkg::msgWord  msg,
	input  bchPkg::codeWord errPattern,
	output logic            ready,
	output logic            doneValid,
	output logic            wrongNow,
	output logic            wrong,
	output bchPkg::msgWord  dout
);
	import bchPkg::*;

	msgWord msgStore;
	msgWord decMsg;
	codeWord errShift;
	logic accept;
	logic codeBit;
	logic bitValid;
	logic rxBit;
	logic wrongSticky;

	assign accept = start && ready;

	// **********************************************************************
	// handshake and block registers
	// **********************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			ready <= 1'b1;
			wrongSticky <= 1'b0;
		end else begin
			if (accept)
				ready <= 1'b0;
			else if (doneValid)
				ready <= 1'b1;
			if (wrongNow)
				wrongSticky <= 1'b1;
		end
	end

	// errPattern bit k hits the k-th transmitted bit.
	always_ff @(posedge clk) begin
		if (accept) begin
			msgStore <= msg;
			errShift <= errPattern;
		end else if (bitValid) begin
			errShift <= errShift >> 1;
		end
	end

	// **********************************************************************
	// encoder, channel and decoder
	// **********************************************************************

	bchEncoder encoder (
		.clk(clk), .reset(reset),
		.load(accept), .msg(msg),
		.codeBit(codeBit), .bitValid(bitValid)
	);

	assign rxBit = codeBit ^ errShift[0];

	bchDecoder decoder (
		.clk(clk), .reset(reset),
		.rxBit(rxBit), .rxValid(bitValid),
		.doneValid(doneValid), .decMsg(decMsg)
	);

	assign dout = decMsg;
	assign wrongNow = doneValid && (decMsg != msgStore);
	assign wrong = wrongSticky || wrongNow;

endmodule

/* include/bchBenchTasks.svh */
`ifndef bchBenchTasksSvh
`define bchBenchTasksSvh

	// random error pattern with exactly the given number of flipped bits.
	function automatic codeWord makePattern(input int weight);
		codeWord pattern;
		bitIndex pos;
		pattern = '0;
		while ($countones(pattern) < weight) begin
			pos = bitIndex'($urandom % codeLen);
			pattern[pos] = 1'b1;
		end
		return pattern;
	endfunction

	task automatic sendBlock(input msgWord m, input codeWord e);
		@(negedge clk);
		while (!ready)
			@(negedge clk);
		@(posedge clk);
		start <= 1'b1;
		msg <= m;
		errPattern <= e;
		sentMsg = m;
		started = 1'b1;
		@(posedge clk);
		start <= 1'b0;
		blockCount = blockCount + 1;
	endtask

	// poke sends a start pulse while the block is still in flight, which must be ignored.
	task automatic waitDone(input bit poke, input bit correctable);
		if (poke) begin
			@(posedge clk);
			start <= 1'b1;
			msg <= ~sentMsg;
			errPattern <= makePattern(3);
			@(posedge clk);
			start <= 1'b0;
		end
		@(negedge clk);
		while (!doneValid)
			@(negedge clk);
		if (correctable) begin
			assert (dout == sentMsg) else reportError("dout", 16'(dout), 16'(sentMsg));
			assert (!wrongNow) else reportError("wrongNow", 16'(wrongNow), 16'h0);
		end
		@(negedge clk);
		assert (!doneValid) else reportError("doneValid", 16'(doneValid), 16'h0);
		assert (ready) else reportError("ready", 16'(ready), 16'h1);
		assert (doneCount == blockCount)
			else reportFailure("the number of doneValid pulses differs from the accepted blocks");
	endtask

`endif

/* bench/bchLoopbackTb.sv */
`timescale 1ns/100ps

module bchLoopbackTb;
	import bchPkg::*;

	// a block takes about 40 cycles from start to doneValid.
	localparam int blockCycles = 40;
	localparam int timeoutCycles = 40 * blockCycles + 200;

	logic clk;
	logic reset;
	logic start;
	msgWord msg;
	codeWord errPattern;
	logic ready;
	logic doneValid;
	logic wrongNow;
	logic wrong;
	msgWord dout;

	logic started = 1'b0;
	logic sawWrong = 1'b0;
	int cycleCount = 0;
	int blockCount = 0;
	int doneCount = 0;
	msgWord sentMsg = '0;

	bchLoopback UUT (
		.clk(clk), .reset(reset), .start(start), .msg(msg), .errPattern(errPattern),
		.ready(ready), .doneValid(doneValid), .wrongNow(wrongNow), .wrong(wrong),
		.dout(dout)
	);

	`include "bchBenchTasks.svh"

	task automatic reportError(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		$display("error %s: got %h, expected %h", name, got, expected);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// **********************************************************************
	// cycle monitor
	// **********************************************************************

	always @(negedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > timeoutCycles)
			reportFailure("timeout: the run did not finish within the cycle limit");
		if (reset) begin
			sawWrong = 1'b0;
		end else begin
			if (!started) begin
				assert (ready) else reportError("ready", 16'(ready), 16'h1);
				assert (!doneValid) else reportError("doneValid", 16'(doneValid), 16'h0);
				assert (!wrongNow) else reportError("wrongNow", 16'(wrongNow), 16'h0);
				assert (!wrong) else reportError("wrong", 16'(wrong), 16'h0);
			end
			if (doneValid) begin
				doneCount = doneCount + 1;
				assert (wrongNow == (dout != sentMsg))
					else reportError("wrongNow", 16'(wrongNow), 16'(dout != sentMsg));
				if (wrongNow)
					sawWrong = 1'b1;
			end
			// the mismatch flag is sticky until the next reset.
			if (sawWrong)
				assert (wrong) else reportError("wrong", 16'(wrong), 16'h1);
		end
	end

	// **********************************************************************
	// stimulus
	// **********************************************************************

	initial begin
		void'($urandom(49669));
		reset = 1'b1;
		start = 1'b0;
		msg = '0;
		errPattern = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk);

		repeat (5) begin
			sendBlock(msgWord'($urandom), '0);
			waitDone(1'b0, 1'b1);
		end

		for (int w = 1; w <= corrCap; w++) begin
			repeat (5) begin
				sendBlock(msgWord'($urandom), makePattern(w));
				waitDone(w == 2, 1'b1);
			end
		end
		// three errors in the message field, then three in the parity field.
		sendBlock(msgWord'($urandom), 15'h0007);
		waitDone(1'b1, 1'b1);
		sendBlock(msgWord'($urandom), 15'h7000);
		waitDone(1'b0, 1'b1);
		@(negedge clk);
		assert (!wrong) else reportError("wrong", 16'(wrong), 16'h0);

		// the generator polynomial is itself a codeword of weight 7, so this pattern
		// lands on another codeword whose message differs in bit 4.
		sendBlock(msgWord'($urandom), 15'h7650);
		waitDone(1'b0, 1'b0);
		assert (wrong) else reportError("wrong", 16'(wrong), 16'h1);

		for (int w = 4; w <= 7; w++) begin
			repeat (2) begin
				sendBlock(msgWord'($urandom), makePattern(w));
				waitDone(1'b0, 1'b0);
			end
		end

		@(posedge clk);
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!wrong) else reportError("wrong", 16'(wrong), 16'h0);
		sendBlock(msgWord'($urandom), makePattern(1));
		waitDone(1'b1, 1'b1);

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+include
design/bchPkg.sv
design/bchEncoder.sv
design/syndromeUnit.sv
design/errorLocator.sv
design/chienCorrector.sv
design/bchDecoder.sv
design/bchLoopback.sv
bench/bchLoopbackTb.sv

/* runSim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module bchLoopbackTb -f sources.f -o simBch

# the simulation exits nonzero on failure, the log search below decides the result.
./obj_dir/simBch > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
	exit 0
else
	exit 1
fi
